/* files.f */
hdl/memPkg.sv
hdl/storeFormat.sv
hdl/memRequest.sv
hdl/dataRam.sv
hdl/loadAlign.sv
hdl/memPipe.sv
tests/tbClock.sv
tests/memPipeTb.sv

/* hdl/dataRam.sv */
`timescale 1ns/1ps

module dataRam import memPkg::*; (
    input  logic                  clk,
    input  logic                  rstN,
    input  dbusReqT   [SLOTS-1:0] dreq,
    output wordT      [SLOTS-1:0] rdata
);

    // word storage, contents undefined after reset
    wordT mem [RAM_WORDS];

    // word index per port
    logic [RAM_INDEX_BITS-1:0] wordIndex [SLOTS];

    always_comb begin
        for (int s = 0; s < SLOTS; s++) begin
            wordIndex[s] = dreq[s].addr[RAM_INDEX_BITS+1:2];
        end
    end

    // byte writes, slot 1 first
    // slot 0 assigned later so it wins on shared lanes
    always_ff @(posedge clk) begin
        for (int s = SLOTS - 1; s >= 0; s--) begin
            if (dreq[s].valid) begin
                for (int b = 0; b < BYTE_LANES; b++) begin
                    if (dreq[s].strobe[b]) begin
                        mem[wordIndex[s]][8*b +: 8] <= dreq[s].data[8*b +: 8];
                    end
                end
            end
        end
    end

    // registered read
    // sees the array before this edge's writes
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rdata <= '0;
        end else begin
            for (int s = 0; s < SLOTS; s++) begin
                // only refresh on an active request
                if (dreq[s].valid) begin
                    rdata[s] <= mem[wordIndex[s]];
                end
            end
        end
    end

endmodule

/* hdl/loadAlign.sv */
`timescale 1ns/1ps

module loadAlign import memPkg::*; (
    input  logic                       clk,
    input  logic                       rstN,
    input  memoryDataT    [SLOTS-1:0]  dataE2,
    input  wordT          [SLOTS-1:0]  rdata,
    output writebackDataT [SLOTS-1:0]  dataW
);

    // control bits of the stage register
    u1 [SLOTS-1:0] validQ;
    u1 [SLOTS-1:0] regwriteQ;

    // payload of the stage register
    memoryDataT [SLOTS-1:0] recQ;

    // pick the addressed byte or halfword and extend it
    function automatic wordT extendLoad(wordT word, logic [1:0] low, msizeT size,
                                        u1 signedLoad);
        logic [7:0]  loadByte;
        logic [15:0] loadHalf;
        loadByte = word[{low, 3'b000} +: 8];
        // halfword loads use bit 1 only
        loadHalf = low[1] ? word[31:16] : word[15:0];
        case (size)
            MSIZE1: begin
                return signedLoad ? {{24{loadByte[7]}}, loadByte} : {24'b0, loadByte};
            end
            MSIZE2: begin
                return signedLoad ? {{16{loadHalf[15]}}, loadHalf} : {16'b0, loadHalf};
            end
            default: begin
                return word;
            end
        endcase
    endfunction

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validQ    <= '0;
            regwriteQ <= '0;
        end else begin
            for (int s = 0; s < SLOTS; s++) begin
                validQ[s]    <= dataE2[s].valid;
                regwriteQ[s] <= dataE2[s].valid && dataE2[s].ctl.regwrite;
            end
        end
    end

    // address, size and result source travel with the ram read
    always_ff @(posedge clk) begin
        recQ <= dataE2;
    end

    for (genvar i = 0; i < SLOTS; i++) begin : gSlot
        always_comb begin
            dataW[i].valid    = validQ[i];
            dataW[i].pc       = recQ[i].pc;
            dataW[i].rdst     = recQ[i].rdst;
            dataW[i].regwrite = regwriteQ[i];
            // load data or plain alu result
            if (recQ[i].ctl.memtoreg) begin
                dataW[i].result = extendLoad(rdata[i], recQ[i].aluOut[1:0],
                                             recQ[i].ctl.msize, recQ[i].ctl.loadSigned);
            end else begin
                dataW[i].result = recQ[i].aluOut;
            end
        end
    end

endmodule

/* hdl/memPipe.sv */
`timescale 1ns/1ps

module memPipe import memPkg::*; (
    input  logic                       clk,
    input  logic                       rstN,
    // slot 1 older, slot 0 younger
    input  executeDataT   [SLOTS-1:0]  dataE,
    output writebackDataT [SLOTS-1:0]  dataW,
    // trap seen in the memory stage
    output u1                          excpM
);

    // bus requests into the ram
    dbusReqT [SLOTS-1:0] dreq;

    // records after the squash
    memoryDataT [SLOTS-1:0] dataE2;

    // raw words from the ram, one edge after the request
    wordT [SLOTS-1:0] rdata;

    // combinational request side
    memRequest request (
        .dataE  (dataE),
        .dreq   (dreq),
        .dataE2 (dataE2),
        .excpM  (excpM)
    );

    // data memory, writes and reads share the request edge
    dataRam ram (
        .clk   (clk),
        .rstN  (rstN),
        .dreq  (dreq),
        .rdata (rdata)
    );

    // memory to writeback register
    // lines up with the registered ram read
    loadAlign align (
        .clk    (clk),
        .rstN   (rstN),
        .dataE2 (dataE2),
        .rdata  (rdata),
        .dataW  (dataW)
    );

endmodule

/* hdl/memPkg.sv */
package memPkg;

    // issue width of the pipeline
    localparam int SLOTS = 2;

    // bytes per data word
    localparam int BYTE_LANES = 4;

    // on-chip data RAM geometry
    localparam int RAM_WORDS = 256;
    // word index comes from addr[9:2]
    localparam int RAM_INDEX_BITS = 8;

    typedef logic u1;
    typedef logic [31:0] wordT;
    typedef logic [BYTE_LANES-1:0] strobeT;

    // access width in bytes
    typedef enum logic [1:0] {
        MSIZE1 = 2'b00,
        MSIZE2 = 2'b01,
        MSIZE4 = 2'b10
    } msizeT;

    // exception class carried from decode
    typedef enum logic [1:0] {
        CNONE     = 2'b00,
        EXCEPTION = 2'b01,
        ERET      = 2'b10
    } ctypeT;

    typedef struct packed {
        ctypeT ctype;
    } cp0CtlT;

    // per-instruction control flags
    typedef struct packed {
        u1     regwrite;
        u1     memtoreg;
        u1     memwrite;
        u1     lowrite;
        u1     hiwrite;
        u1     cp0write;
        msizeT msize;
        // sign extension for lb/lh
        u1     loadSigned;
    } ctlT;

    // record coming out of execute
    typedef struct packed {
        u1          valid;
        wordT       pc;
        logic [4:0] rdst;
        ctlT        ctl;
        cp0CtlT     cp0Ctl;
        // instruction sits in a delay slot
        u1          isSlot;
        // effective address or alu result
        wordT       aluOut;
        // store data
        wordT       srcb;
    } executeDataT;

    // record leaving memory, ctl may be squashed
    typedef struct packed {
        u1          valid;
        wordT       pc;
        logic [4:0] rdst;
        ctlT        ctl;
        cp0CtlT     cp0Ctl;
        u1          isSlot;
        wordT       aluOut;
        wordT       srcb;
    } memoryDataT;

    // data bus request, strobe zero means read
    typedef struct packed {
        u1      valid;
        wordT   addr;
        msizeT  size;
        strobeT strobe;
        wordT   data;
    } dbusReqT;

    // record into writeback
    typedef struct packed {
        u1          valid;
        wordT       pc;
        logic [4:0] rdst;
        u1          regwrite;
        wordT       result;
    } writebackDataT;

    // exception or eret both redirect the pipe
    function automatic u1 isTrap(cp0CtlT cp0Ctl);
        return (cp0Ctl.ctype == EXCEPTION) || (cp0Ctl.ctype == ERET);
    endfunction

endpackage

/* hdl/memRequest.sv */
`timescale 1ns/1ps

module memRequest import memPkg::*; (
    input  executeDataT [SLOTS-1:0] dataE,
    output dbusReqT     [SLOTS-1:0] dreq,
    output memoryDataT  [SLOTS-1:0] dataE2,
    output u1                       excpM
);

    // store lanes per slot
    wordT   [SLOTS-1:0] laneData;
    strobeT [SLOTS-1:0] laneStrobe;

    // a trap in older slot 1 kills younger slot 0
    u1 squashYoung;

    assign squashYoung = dataE[1].valid && isTrap(dataE[1].cp0Ctl);

    for (genvar i = 0; i < SLOTS; i++) begin : gSlot

        storeFormat storeFmt (
            .addrLow   (dataE[i].aluOut[1:0]),
            .storeData (dataE[i].srcb),
            .size      (dataE[i].ctl.msize),
            .laneData  (laneData[i]),
            .strobe    (laneStrobe[i])
        );

        // record copy into the memory stage
        always_comb begin
            dataE2[i].valid  = dataE[i].valid;
            dataE2[i].pc     = dataE[i].pc;
            dataE2[i].rdst   = dataE[i].rdst;
            dataE2[i].ctl    = dataE[i].ctl;
            dataE2[i].cp0Ctl = dataE[i].cp0Ctl;
            dataE2[i].isSlot = dataE[i].isSlot;
            dataE2[i].aluOut = dataE[i].aluOut;
            dataE2[i].srcb   = dataE[i].srcb;
            // drop every architectural side effect of a squashed slot
            if (i == 0 && squashYoung) begin
                dataE2[i].ctl.regwrite = 1'b0;
                dataE2[i].ctl.memtoreg = 1'b0;
                dataE2[i].ctl.memwrite = 1'b0;
                dataE2[i].ctl.lowrite  = 1'b0;
                dataE2[i].ctl.hiwrite  = 1'b0;
                dataE2[i].ctl.cp0write = 1'b0;
            end
        end

        // one bus request per cycle and never held
        always_comb begin
            dreq[i] = '0;
            if (dataE[i].valid && !(i == 0 && squashYoung)) begin
                if (dataE[i].ctl.memtoreg) begin
                    // load requests carry a zero strobe
                    dreq[i].valid = 1'b1;
                    dreq[i].addr  = dataE[i].aluOut;
                    dreq[i].size  = dataE[i].ctl.msize;
                end else if (dataE[i].ctl.memwrite) begin
                    dreq[i].valid  = 1'b1;
                    dreq[i].addr   = dataE[i].aluOut;
                    dreq[i].size   = dataE[i].ctl.msize;
                    dreq[i].strobe = laneStrobe[i];
                    dreq[i].data   = laneData[i];
                end
            end
        end

    end

    // either valid slot trapping redirects fetch
    assign excpM = (dataE[1].valid && isTrap(dataE[1].cp0Ctl))
                || (dataE[0].valid && isTrap(dataE[0].cp0Ctl));

endmodule

/* hdl/storeFormat.sv */
`timescale 1ns/1ps

module storeFormat import memPkg::*; (
    input  logic [1:0] addrLow,
    input  wordT       storeData,
    input  msizeT      size,
    output wordT       laneData,
    output strobeT     strobe
);

    // byte data is copied to every lane so the strobe alone picks the target
    always_comb begin
        case (size)
            MSIZE1: begin
                laneData = {4{storeData[7:0]}};
            end
            MSIZE2: begin
                laneData = {2{storeData[15:0]}};
            end
            default: begin
                laneData = storeData;
            end
        endcase
    end

    // strobe from address low bits
    always_comb begin
        case (size)
            MSIZE1: begin
                // one lane per byte offset
                strobe = strobeT'(4'b0001 << addrLow);
            end
            MSIZE2: begin
                // upper or lower halfword, bit 0 ignored
                if (addrLow[1]) begin
                    strobe = 4'b1100;
                end else begin
                    strobe = 4'b0011;
                end
            end
            default: begin
                // full word
                strobe = 4'b1111;
            end
        endcase
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
# build and run the memory stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module memPipeTb -f files.f -o memPipeSim
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
    echo "verilator build failed with status $buildStatus"
    exit 1
fi

simOutput=$(./obj_dir/memPipeSim)
simStatus=$?
echo "$simOutput"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if echo "$simOutput" | grep -qxF '** PASS **'; then
    exit 0
fi
exit 1

/* tests/memPipeTb.sv */
`timescale 1ns/1ps

module memPipeTb import memPkg::*; ();

    typedef writebackDataT [SLOTS-1:0] wbPairT;
    typedef enum {opAlu, opLoad, opStore} kindT;

    logic clk;
    logic rstN;
    executeDataT [SLOTS-1:0] dataE;
    writebackDataT [SLOTS-1:0] dataW;
    u1 excpM;

    // byte image of the ram
    logic [7:0] shadow [1024];
    // predictions waiting for their edge
    wbPairT pending [$];
    wbPairT expCur;
    u1 haveExp = 1'b0;
    u1 expExcp = 1'b0;
    integer seed;
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int failedTests = 0;
    int errorsBefore = 0;

    tbClock clockGen (
        .clk  (clk),
        .rstN (rstN)
    );

    memPipe i_memPipe (
        .clk   (clk),
        .rstN  (rstN),
        .dataE (dataE),
        .dataW (dataW),
        .excpM (excpM)
    );

    function automatic u1 trapRef(input executeDataT e);
        return e.valid && (e.cp0Ctl.ctype == EXCEPTION || e.cp0Ctl.ctype == ERET);
    endfunction

    function automatic executeDataT makeOp(input u1 valid, input kindT kind, input msizeT size,
                                           input u1 sgn, input wordT addr, input wordT data,
                                           input ctypeT ctype);
        executeDataT r;
        r = '0;
        r.valid = valid;
        // pc and rdst only need to be distinct per op
        r.pc = {addr[23:0], 8'h00} ^ data;
        r.rdst = addr[6:2] ^ data[4:0];
        r.ctl.regwrite = (kind != opStore);
        r.ctl.memtoreg = (kind == opLoad);
        r.ctl.memwrite = (kind == opStore);
        r.ctl.msize = size;
        r.ctl.loadSigned = sgn;
        r.cp0Ctl.ctype = ctype;
        r.isSlot = addr[3];
        r.aluOut = addr;
        r.srcb = data;
        return r;
    endfunction

    function automatic executeDataT storeOp(input msizeT size, input wordT addr, input wordT data);
        return makeOp(1'b1, opStore, size, 1'b0, addr, data, CNONE);
    endfunction

    function automatic executeDataT loadOp(input msizeT size, input u1 sgn, input wordT addr);
        return makeOp(1'b1, opLoad, size, sgn, addr, 32'h0, CNONE);
    endfunction

    function automatic executeDataT aluOp(input wordT value, input ctypeT ctype);
        return makeOp(1'b1, opAlu, MSIZE4, 1'b0, value, 32'h0, ctype);
    endfunction

    // fill value depends on every address bit
    function automatic wordT fillWord(input int byteAddr);
        return byteAddr * 32'h9E3779B1 ^ 32'h0F1E2D3C;
    endfunction

    // writeback prediction for one slot from the shadow bytes
    function automatic writebackDataT predictSlot(input executeDataT e, input u1 live);
        writebackDataT w;
        logic [9:0] a;
        logic [9:0] h;
        logic [9:0] wb;
        logic [7:0] b;
        logic [15:0] half;
        a = e.aluOut[9:0];
        h = {a[9:1], 1'b0};
        wb = {a[9:2], 2'b00};
        b = shadow[a];
        half = {shadow[h + 10'd1], shadow[h]};
        w.valid = e.valid;
        w.pc = e.pc;
        w.rdst = e.rdst;
        w.regwrite = e.valid && e.ctl.regwrite && live;
        w.result = e.aluOut;
        if (e.ctl.memtoreg && live) begin
            case (e.ctl.msize)
                MSIZE1: w.result = e.ctl.loadSigned ? {{24{b[7]}}, b} : {24'h0, b};
                MSIZE2: w.result = e.ctl.loadSigned ? {{16{half[15]}}, half} : {16'h0, half};
                default: w.result = {shadow[wb + 10'd3], shadow[wb + 10'd2],
                                     shadow[wb + 10'd1], shadow[wb]};
            endcase
        end
        return w;
    endfunction

    function automatic void applyStore(input executeDataT e, input u1 live);
        logic [9:0] a;
        logic [9:0] h;
        a = e.aluOut[9:0];
        h = {a[9:1], 1'b0};
        if (e.valid && live && e.ctl.memwrite && !e.ctl.memtoreg) begin
            case (e.ctl.msize)
                MSIZE1: shadow[a] = e.srcb[7:0];
                MSIZE2: begin
                    shadow[h] = e.srcb[7:0];
                    shadow[h + 10'd1] = e.srcb[15:8];
                end
                default: begin
                    shadow[{a[9:2], 2'd0}] = e.srcb[7:0];
                    shadow[{a[9:2], 2'd1}] = e.srcb[15:8];
                    shadow[{a[9:2], 2'd2}] = e.srcb[23:16];
                    shadow[{a[9:2], 2'd3}] = e.srcb[31:24];
                end
            endcase
        end
    endfunction

    // reference model for one issued pair
    function automatic wbPairT predict(input executeDataT older, input executeDataT younger);
        wbPairT w;
        u1 kill;
        kill = trapRef(older);
        // loads see memory as it was before this pair
        w[1] = predictSlot(older, 1'b1);
        w[0] = predictSlot(younger, !kill);
        // older store first so younger wins on shared bytes
        applyStore(older, 1'b1);
        applyStore(younger, !kill);
        return w;
    endfunction

    function automatic executeDataT randomOp();
        logic [31:0] r;
        wordT addr;
        wordT data;
        kindT kind;
        msizeT size;
        ctypeT ctype;
        r = $random(seed);
        addr = $random(seed);
        data = $random(seed);
        case (r[1:0])
            2'd1: kind = opLoad;
            2'd2: kind = opStore;
            default: kind = opAlu;
        endcase
        case (r[5:4])
            2'd0: size = MSIZE1;
            2'd1: size = MSIZE2;
            default: size = MSIZE4;
        endcase
        // traps in about one op in eight
        if (r[11:8] == 4'd0) begin
            ctype = EXCEPTION;
        end else if (r[11:8] == 4'd1) begin
            ctype = ERET;
        end else begin
            ctype = CNONE;
        end
        return makeOp(r[2] | r[3], kind, size, r[6], addr, data, ctype);
    endfunction

    task automatic issue(input executeDataT older, input executeDataT younger);
        @(posedge clk);
        #1;
        dataE[1] = older;
        dataE[0] = younger;
        expExcp = trapRef(older) || trapRef(younger);
        pending.push_back(predict(older, younger));
    endtask

    task automatic idle();
        @(posedge clk);
        #1;
        dataE = '0;
        expExcp = 1'b0;
    endtask

    // run idle pairs until every prediction has been compared
    task automatic drain();
        int n;
        n = 0;
        while ((pending.size() > 0 || haveExp) && n < 20) begin
            idle();
            n++;
        end
        if (pending.size() > 0 || haveExp) begin
            $display("timeout: results still outstanding after 20 idle cycles");
            errors++;
        end
    endtask

    task automatic finishTest(input string name);
        tests++;
        if (errors != errorsBefore) begin
            failedTests++;
        end
        $display("test %-8s %0d errors", name, errors - errorsBefore);
        errorsBefore = errors;
    endtask

    task automatic checkSlot(input int i, input writebackDataT got, input writebackDataT exp);
        checks++;
        if (got.valid !== exp.valid) begin
            $display("error dataW[%0d].valid got %h expected %h", i, got.valid, exp.valid);
            errors++;
        end
        if (got.regwrite !== exp.regwrite) begin
            $display("error dataW[%0d].regwrite got %h expected %h", i, got.regwrite, exp.regwrite);
            errors++;
        end
        if (exp.valid) begin
            if (got.pc !== exp.pc) begin
                $display("error dataW[%0d].pc got %h expected %h", i, got.pc, exp.pc);
                errors++;
            end
            if (got.rdst !== exp.rdst) begin
                $display("error dataW[%0d].rdst got %h expected %h", i, got.rdst, exp.rdst);
                errors++;
            end
            if (got.result !== exp.result) begin
                $display("error dataW[%0d].result got %h expected %h", i, got.result, exp.result);
                errors++;
            end
        end
    endtask

    // the edge that registers a pair makes its prediction current
    always @(posedge clk) begin
        if (pending.size() > 0) begin
            expCur = pending.pop_front();
            haveExp = 1'b1;
        end else begin
            haveExp = 1'b0;
        end
    end

    // outputs are stable mid cycle
    always @(negedge clk) begin
        if (rstN) begin
            if (haveExp) begin
                checkSlot(1, dataW[1], expCur[1]);
                checkSlot(0, dataW[0], expCur[0]);
            end
            checks++;
            if (excpM !== expExcp) begin
                $display("error excpM got %h expected %h", excpM, expExcp);
                errors++;
            end
        end
    end

    initial begin
        int n;
        seed = 71;
        // valid ops held during reset must not reach dataW
        dataE[1] = aluOp(32'h11, CNONE);
        dataE[0] = aluOp(32'h22, CNONE);
        repeat (2) @(negedge clk);
        if (rstN) begin
            $display("reset released before the reset check");
            errors++;
        end
        if (dataW[1].valid !== 1'b0 || dataW[0].valid !== 1'b0) begin
            $display("error dataW valid in reset got %h %h expected 0 0",
                     dataW[1].valid, dataW[0].valid);
            errors++;
        end
        if (dataW[1].regwrite !== 1'b0 || dataW[0].regwrite !== 1'b0) begin
            $display("error dataW regwrite in reset got %h %h expected 0 0",
                     dataW[1].regwrite, dataW[0].regwrite);
            errors++;
        end
        dataE = '0;
        n = 0;
        while (!rstN && n < 10) begin
            @(posedge clk);
            n++;
        end
        if (!rstN) begin
            $display("timeout: reset never released");
            errors++;
        end
        finishTest("reset");

        // every ram word gets a known value before any load
        for (int k = 0; k < 128; k++) begin
            issue(storeOp(MSIZE4, 8 * k, fillWord(8 * k)),
                  storeOp(MSIZE4, 8 * k + 4, fillWord(8 * k + 4)));
        end
        drain();
        finishTest("fill");

        issue(storeOp(MSIZE4, 32'h40, 32'hDEADBEEF), makeOp(1'b0, opAlu, MSIZE4, 1'b0, 0, 0, CNONE));
        issue(loadOp(MSIZE4, 1'b0, 32'h40), aluOp(32'h55, CNONE));
        issue(aluOp(32'h66, CNONE), storeOp(MSIZE4, 32'h44, 32'h8BADF00D));
        issue(aluOp(32'h77, CNONE), loadOp(MSIZE4, 1'b1, 32'h44));
        drain();
        finishTest("word");

        for (int off = 0; off < 4; off++) begin
            issue(storeOp(MSIZE1, 32'h100 + off, 32'hFFFFFF80 + off), aluOp(off, CNONE));
            issue(loadOp(MSIZE1, 1'b1, 32'h100 + off), loadOp(MSIZE1, 1'b0, 32'h100 + off));
            issue(storeOp(MSIZE2, 32'h120 + off, 32'h7F008001 + 32'h111 * off), aluOp(off, CNONE));
            issue(loadOp(MSIZE2, 1'b1, 32'h120 + off), loadOp(MSIZE2, 1'b0, 32'h120 + off));
        end
        drain();
        finishTest("subword");

        issue(storeOp(MSIZE4, 32'h200, 32'h11223344), storeOp(MSIZE1, 32'h201, 32'hAB));
        issue(loadOp(MSIZE4, 1'b0, 32'h200), storeOp(MSIZE2, 32'h204, 32'h5555));
        issue(storeOp(MSIZE4, 32'h208, 32'hCAFEF00D), loadOp(MSIZE4, 1'b0, 32'h208));
        issue(loadOp(MSIZE2, 1'b1, 32'h20A), storeOp(MSIZE2, 32'h20A, 32'h0123));
        issue(loadOp(MSIZE4, 1'b0, 32'h208), loadOp(MSIZE4, 1'b0, 32'h204));
        issue(aluOp(32'h12345678, CNONE), aluOp(32'h9ABCDEF0, CNONE));
        drain();
        finishTest("dual");

        issue(aluOp(32'h1000, EXCEPTION), storeOp(MSIZE4, 32'h300, 32'hFFFFFFFF));
        issue(loadOp(MSIZE4, 1'b0, 32'h300), aluOp(32'h1004, CNONE));
        issue(aluOp(32'h2000, ERET), loadOp(MSIZE4, 1'b1, 32'h300));
        issue(storeOp(MSIZE4, 32'h304, 32'h0BADC0DE), aluOp(32'h3000, EXCEPTION));
        issue(loadOp(MSIZE4, 1'b0, 32'h304), aluOp(32'h3004, ERET));
        drain();
        finishTest("squash");

        for (int c = 0; c < 300; c++) begin
            issue(randomOp(), randomOp());
        end
        drain();
        finishTest("random");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failedTests, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* tests/tbClock.sv */
`timescale 1ns/1ps

module tbClock (
    output logic clk,
    output logic rstN
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reset low for three rising edges, released just after the third
    initial begin
        rstN = 1'b0;
        repeat (3) @(posedge clk);
        #1 rstN = 1'b1;
    end

endmodule
